/* common/dot_pkg.sv */
`default_nettype none

package dot_pkg;

  //////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////

  typedef logic signed [7:0]  operand_t;  // int8 operand
  typedef logic signed [15:0] prod_t;     // full 8x8 product
  typedef logic signed [23:0] acc_t;      // room for 255 worst-case products
  typedef logic [7:0]         result_t;   // activated output, 0..127
  typedef logic [7:0]         len_t;      // vector length, sticks at 255

  //////////////////////////////////////////////////
  // stream payloads and tags
  //////////////////////////////////////////////////

  // input stream, one operand pair per beat
  typedef struct packed {
    operand_t a;
    operand_t b;
    logic     last;   // closes the vector
  } pair_s;

  // tag riding beside a product through the multiplier
  typedef struct packed {
    logic valid;
    logic last;
  } term_s;

  // output stream, one beat per vector
  typedef struct packed {
    result_t value;
    len_t    len;
    logic    sat;     // value was clamped to 127
  } result_s;

  // control FSM
  typedef enum logic {
    S_RUN,    // taking pairs
    S_HOLD    // last pair taken, waiting on result transfer
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/mult_8_bit.sv */
`default_nettype none

// signed 8x8 multiplier
// MULT_MODE 0: shift-add, comb
// MULT_MODE 1: shift-add, one register
// MULT_MODE 2: operator, comb
// MULT_MODE 3: operator, one register
module mult_8_bit import dot_pkg::*; #(
  parameter int MULT_MODE = 1
) (
  input  wire      clk,
  input  operand_t a_i,
  input  operand_t b_i,
  output prod_t    p_o
);

  prod_t p_comb;  // product before the optional register

  //////////////////////////////////////////////////
  // product
  //////////////////////////////////////////////////

  generate
    if (MULT_MODE == 0 || MULT_MODE == 1) begin : g_shift_add
      logic [7:0]  a_mag;  // -128 maps to 128, still fits
      logic [7:0]  b_mag;
      logic [15:0] p_mag;

      assign a_mag = a_i[7] ? 8'(-a_i) : 8'(a_i);
      assign b_mag = b_i[7] ? 8'(-b_i) : 8'(b_i);

      // one partial product per magnitude bit of b
      always_comb begin
        p_mag = '0;
        for (int i = 0; i < 8; i++) begin
          if (b_mag[i]) begin
            p_mag = p_mag + (16'(a_mag) << i);
          end
        end
      end

      // magnitude tops out at 16384, so the sign bit is free
      assign p_comb = (a_i[7] ^ b_i[7]) ? -prod_t'(p_mag) : prod_t'(p_mag);
    end else begin : g_operator
      assign p_comb = a_i * b_i;  // both signed, sign extended to 16
    end
  endgenerate

  //////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////

  generate
    if (MULT_MODE == 1 || MULT_MODE == 3) begin : g_reg
      prod_t p_q;

      always_ff @(posedge clk) begin
        p_q <= p_comb;
      end

      assign p_o = p_q;
    end else begin : g_comb
      assign p_o = p_comb;
    end
  endgenerate

endmodule

`default_nettype wire

/* dot_engine/dot_ctrl.sv */
`default_nettype none

// control hub: input acceptance, term tags, length count, output valid
module dot_ctrl import dot_pkg::*; #(
  parameter int MULT_MODE = 1
) (
  input  wire   clk,
  input  wire   rst_i,
  input  wire   in_valid_i,
  input  wire   in_last_i,
  output logic  in_ready_o,
  output term_s term_o,
  output logic  load_o,
  output len_t  len_o,
  input  wire   out_ready_i,
  output logic  out_valid_o
);

  // registered multiplier modes add one cycle
  localparam int LAT = (MULT_MODE == 1 || MULT_MODE == 3) ? 1 : 0;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  logic  accept;
  logic  out_fire;
  logic  out_valid_q;
  len_t  cnt_q;
  len_t  cnt_inc;
  term_s issue;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  assign in_ready_o  = (state_q == S_RUN);
  assign accept      = in_valid_i & in_ready_o;
  assign out_valid_o = out_valid_q;
  assign out_fire    = out_valid_q & out_ready_i;

  // tag for the pair taken this cycle
  assign issue.valid = accept;
  assign issue.last  = accept & in_last_i;

  //////////////////////////////////////////////////
  // tag delay line, lines up with p_o
  //////////////////////////////////////////////////

  generate
    if (LAT == 0) begin : g_no_delay
      assign term_o = issue;
    end else begin : g_delay
      term_s tag_q [LAT];

      always_ff @(posedge clk) begin
        if (rst_i) begin
          for (int i = 0; i < LAT; i++) begin
            tag_q[i] <= '0;
          end
        end else begin
          tag_q[0] <= issue;
          for (int i = 1; i < LAT; i++) begin
            tag_q[i] <= tag_q[i-1];
          end
        end
      end

      assign term_o = tag_q[LAT-1];
    end
  endgenerate

  //////////////////////////////////////////////////
  // length and result load
  //////////////////////////////////////////////////

  assign cnt_inc = (cnt_q == 8'hff) ? cnt_q : cnt_q + 8'd1;  // sticks at 255

  // without a multiplier register the last tag is the current accept,
  // which the count does not hold yet
  assign len_o  = accept ? cnt_inc : cnt_q;
  assign load_o = term_o.valid & term_o.last;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_RUN: begin
        if (accept && in_last_i) begin
          state_d = S_HOLD;
        end
      end
      S_HOLD: begin
        if (out_fire) begin
          state_d = S_RUN;  // pipeline is empty by now
        end
      end
      default: state_d = S_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= S_RUN;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;

      if (load_o) begin
        out_valid_q <= 1'b1;
      end else if (out_fire) begin
        out_valid_q <= 1'b0;
      end

      if (out_fire) begin
        cnt_q <= '0;
      end else if (accept) begin
        cnt_q <= cnt_inc;
      end
    end
  end

endmodule

`default_nettype wire

/* dot_engine/dot_accum.sv */
`default_nettype none

// running sum of tagged products
module dot_accum import dot_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  input  term_s term_i,
  input  prod_t prod_i,
  output acc_t  sum_o
);

  acc_t acc_q;
  acc_t prod_ext;
  acc_t sum_w;

  //////////////////////////////////////////////////
  // add
  //////////////////////////////////////////////////

  assign prod_ext = acc_t'(prod_i);  // sign extend 16 -> 24
  assign sum_w    = acc_q + prod_ext;

  // only meaningful while a last tag is present
  assign sum_o = sum_w;

  //////////////////////////////////////////////////
  // accumulator register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc_q <= '0;
    end else if (term_i.valid) begin
      if (term_i.last) begin
        acc_q <= '0;      // next vector starts clean
      end else begin
        acc_q <= sum_w;
      end
    end
  end

endmodule

`default_nettype wire

/* dot_engine/dot_activate.sv */
`default_nettype none

// ReLU, fixed right shift, clamp to 0..127, result register
module dot_activate import dot_pkg::*; #(
  parameter int ACT_SHIFT = 4
) (
  input  wire     clk,
  input  wire     rst_i,
  input  wire     load_i,
  input  acc_t    sum_i,
  input  len_t    len_i,
  output result_s res_o
);

  acc_t    relu;
  acc_t    shifted;
  logic    clamp;
  result_t value;
  result_s res_q;

  //////////////////////////////////////////////////
  // activation
  //////////////////////////////////////////////////

  assign relu    = sum_i[$bits(acc_t)-1] ? '0 : sum_i;  // negative -> 0
  assign shifted = relu >>> ACT_SHIFT;

  assign clamp = (shifted > acc_t'(127));
  assign value = clamp ? result_t'(127) : shifted[7:0];

  //////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////

  // held until the next vector finishes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_q <= '0;
    end else if (load_i) begin
      res_q.value <= value;
      res_q.len   <= len_i;
      res_q.sat   <= clamp;
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

/* hdl/dot_top.sv */
`default_nettype none

// int8 dot-product engine
module dot_top import dot_pkg::*; #(
  parameter int MULT_MODE = 1,
  parameter int ACT_SHIFT = 4
) (
  input  wire     clk,
  input  wire     rst_i,
  input  wire     in_valid_i,
  output logic    in_ready_o,
  input  pair_s   in_data_i,
  output logic    out_valid_o,
  input  wire     out_ready_i,
  output result_s out_data_o
);

  term_s term;   // tag aligned with prod
  prod_t prod;
  acc_t  sum;
  logic  load;
  len_t  len;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  dot_ctrl #(
    .MULT_MODE (MULT_MODE)
  ) dot_ctrl_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_last_i   (in_data_i.last),
    .in_ready_o  (in_ready_o),
    .term_o      (term),
    .load_o      (load),
    .len_o       (len),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  mult_8_bit #(
    .MULT_MODE (MULT_MODE)
  ) mult_8_bit_inst (
    .clk (clk),
    .a_i (in_data_i.a),   // straight from the input port
    .b_i (in_data_i.b),
    .p_o (prod)
  );

  dot_accum dot_accum_inst (
    .clk    (clk),
    .rst_i  (rst_i),
    .term_i (term),
    .prod_i (prod),
    .sum_o  (sum)
  );

  dot_activate #(
    .ACT_SHIFT (ACT_SHIFT)
  ) dot_activate_inst (
    .clk    (clk),
    .rst_i  (rst_i),
    .load_i (load),
    .sum_i  (sum),
    .len_i  (len),
    .res_o  (out_data_o)
  );

endmodule

`default_nettype wire

/* verif/dot_tb.sv */
`default_nettype none

module dot_tb import dot_pkg::*; #(
  parameter int MULT_MODE = 1,
  parameter int ACT_SHIFT = 4
);

  localparam int LAT   = (MULT_MODE == 1 || MULT_MODE == 3) ? 1 : 0;
  localparam int LIMIT = 500;  // cycles allowed per wait

  logic    clk;
  logic    rst_i;
  logic    in_valid;
  logic    in_ready;
  pair_s   in_data;
  logic    out_valid;
  logic    out_ready;
  result_s out_data;

  logic    throttle;   // random out_ready when set
  result_s exp_head;
  logic    exp_avail;
  int      sent;
  int      received;

  operand_t vec_a[$];
  operand_t vec_b[$];
  result_s  model_q[$];

  dot_top #(
    .MULT_MODE (MULT_MODE),
    .ACT_SHIFT (ACT_SHIFT)
  ) dot_top_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_data_i   (in_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_data_o  (out_data)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // relu, shift, clamp to 0..127
  function automatic result_s expected_result(input int sum, input int count);
    result_s r;
    int      shifted;
    r.len = (count > 255) ? 8'd255 : 8'(count);
    if (sum < 0) begin
      r.value = '0;
      r.sat   = 1'b0;
    end else begin
      shifted = sum >>> ACT_SHIFT;
      r.sat   = (shifted > 127);
      r.value = r.sat ? 8'd127 : 8'(shifted);
    end
    return r;
  endfunction

  task automatic fill_const(input operand_t a, input operand_t b, input int len);
    vec_a.delete();
    vec_b.delete();
    for (int i = 0; i < len; i++) begin
      vec_a.push_back(a);
      vec_b.push_back(b);
    end
  endtask

  task automatic fill_random(input int len);
    vec_a.delete();
    vec_b.delete();
    for (int i = 0; i < len; i++) begin
      vec_a.push_back(operand_t'($urandom_range(0, 255)));
      vec_b.push_back(operand_t'($urandom_range(0, 255)));
    end
  endtask

  // positive a times negative b gives a sum below zero
  task automatic fill_negative(input int len);
    vec_a.delete();
    vec_b.delete();
    for (int i = 0; i < len; i++) begin
      vec_a.push_back(operand_t'($urandom_range(1, 127)));
      vec_b.push_back(operand_t'($urandom_range(128, 255)));
    end
  endtask

  task automatic send_vector(input logic gaps);
    int total;
    int n;
    int idle;
    int waited;
    int lat;
    n     = vec_a.size();
    total = 0;
    for (int i = 0; i < n; i++) begin
      total += int'(vec_a[i]) * int'(vec_b[i]);
    end
    model_q.push_back(expected_result(total, n));
    sent++;
    for (int i = 0; i < n; i++) begin
      idle     = gaps ? int'($urandom_range(0, 2)) : 0;
      in_valid = 1'b0;
      repeat (idle) @(negedge clk);
      in_valid     = 1'b1;
      in_data.a    = vec_a[i];
      in_data.b    = vec_b[i];
      in_data.last = (i == n - 1);
      waited = 0;
      while (!in_ready) begin
        @(negedge clk);
        waited++;
        if (waited > LIMIT) stop_with("input port never became ready");
      end
      @(negedge clk);  // taken on the edge just passed
    end
    in_valid = 1'b0;
    // cycles from the last accept to out_valid
    lat = 1;
    while (!out_valid) begin
      @(negedge clk);
      lat++;
      if (lat > LIMIT) stop_with("no result appeared after the last pair");
    end
    result_delay: assert (lat == LAT + 1)
      else stop_with($sformatf("ERR %0t: result after %0d cycles, expected %0d",
                               $time, lat, LAT + 1));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (model_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > LIMIT) stop_with("results still pending at the end of the run");
    end
  endtask

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    out_ready = throttle ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  // retire the model head on each transfer
  always @(posedge clk) begin
    if (rst_i) begin
      exp_avail <= 1'b0;
      exp_head  <= '0;
    end else begin
      if (out_valid && out_ready) begin
        received++;
        if (model_q.size() != 0) begin
          model_q.delete(0);
        end
      end
      exp_avail <= (model_q.size() != 0);
      if (model_q.size() != 0) exp_head <= model_q[0];
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  out_matches_model: assert property (@(posedge clk) disable iff (rst_i)
    (out_valid && out_ready) |-> (exp_avail && out_data == exp_head))
    else stop_with($sformatf("ERR %0t: result %h, expected %h, pending %0b",
                             $time, out_data, exp_head, exp_avail));

  held_while_stalled: assert property (@(posedge clk) disable iff (rst_i)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else stop_with($sformatf("ERR %0t: result changed before transfer", $time));

  stall_after_last: assert property (@(posedge clk) disable iff (rst_i)
    (in_valid && in_ready && in_data.last) |=> !in_ready)
    else stop_with($sformatf("ERR %0t: input ready right after a last pair", $time));

  stall_until_taken: assert property (@(posedge clk) disable iff (rst_i)
    (!in_ready && !(out_valid && out_ready)) |=> !in_ready)
    else stop_with($sformatf("ERR %0t: input ready before result transfer", $time));

  one_result_held: assert property (@(posedge clk) disable iff (rst_i)
    out_valid |-> !in_ready)
    else stop_with($sformatf("ERR %0t: input ready while a result waits", $time));

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb0e7));
    clk       = 1'b0;
    rst_i     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    throttle  = 1'b0;
    sent      = 0;
    received  = 0;
    repeat (5) @(negedge clk);
    rst_i = 1'b0;

    reset_state: assert (!out_valid && in_ready)
      else stop_with($sformatf("ERR %0t: wrong handshake state after reset", $time));

    // extreme single products
    fill_const(-8'sd128, -8'sd128, 1);
    send_vector(1'b0);
    fill_const(-8'sd128, 8'sd127, 1);
    send_vector(1'b0);
    fill_const(8'sd127, 8'sd127, 1);
    send_vector(1'b0);
    fill_const(8'sd0, -8'sd77, 1);
    send_vector(1'b0);

    repeat (30) begin
      fill_random(int'($urandom_range(1, 40)));
      send_vector(1'b0);
    end

    repeat (4) begin
      fill_negative(int'($urandom_range(1, 12)));
      send_vector(1'b0);
    end
    fill_const(-8'sd128, -8'sd128, 8);
    send_vector(1'b0);
    fill_const(8'sd127, 8'sd127, 260);  // length count sticks at 255
    send_vector(1'b0);

    // back-pressure and input gaps
    throttle = 1'b1;
    repeat (40) begin
      fill_random(int'($urandom_range(1, 40)));
      send_vector(1'b1);
    end

    wait_drained();
    // a valid left over here is a result nobody asked for
    if (out_valid || received != sent) begin
      stop_with($sformatf("ERR %0t: %0d results sent, %0d received, out_valid %0b",
                          $time, sent, received, out_valid));
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
common/dot_pkg.sv
hdl/mult_8_bit.sv
dot_engine/dot_ctrl.sv
dot_engine/dot_accum.sv
dot_engine/dot_activate.sv
hdl/dot_top.sv
verif/dot_tb.sv

/* Makefile */
# multiplier mode handed to the testbench top
MODE ?= 1
SRCS := $(shell cat verilog.f)

all: run

obj_dir/Vdot_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module dot_tb \
		-GMULT_MODE=$(MODE) -f verilog.f -o Vdot_tb

run: obj_dir/Vdot_tb
	obj_dir/Vdot_tb

clean:
	rm -rf obj_dir

.PHONY: all run clean
